//--- src/flash_pkg.sv
package flash_pkg;

	localparam int NUM_BANKS = 4;
	localparam int BANK_W = 2;
	localparam int WORD_ADDR_W = 22; // Address bits 22:1
	localparam int FLASH_ADDR_W = 23;
	localparam int DATA_W = 16;

	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;

	// Address map
	localparam int BANK_LSB = 23;
	localparam int CFG_BIT = 31; // Set selects register space

	localparam int WAIT_W = 9;
	localparam logic [WAIT_W-1:0] WAIT_RESET = 9'd3;

	localparam int ORDER_DEPTH = 4;
	localparam int ORDER_PTR_W = $clog2(ORDER_DEPTH);

	localparam logic [DATA_W-1:0] CMD_READ_ARRAY = 16'h00ff;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// One-hot bit positions of the engine sequence, in order
	localparam int PH_IDLE = 0;
	localparam int PH_CMD = 1;
	localparam int PH_WE = 2;
	localparam int PH_OE = 3;
	localparam int PH_CAP = 4;
	localparam int PH_DONE = 5;
	localparam int PH_RSP = 6;

endpackage

//--- src/flash_bank_if.sv
`timescale 1ns/1ns

interface flash_bank_if import flash_pkg::*; ();

	logic req_valid;
	logic req_ready;
	logic [WORD_ADDR_W-1:0] req_addr; // Word address inside the chip

	logic rsp_valid;
	logic rsp_ready;
	logic [DATA_W-1:0] rsp_data;

	modport disp (
		output req_valid, req_addr,
		input req_ready
	);

	modport engine (
		input req_valid, req_addr, rsp_ready,
		output req_ready, rsp_valid, rsp_data
	);

	modport coll (
		input rsp_valid, rsp_data,
		output rsp_ready
	);

endinterface

//--- src/flash_axi_front.sv
`timescale 1ns/1ns

module flash_axi_front import flash_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [AXI_DATA_W-1:0] wdata,
	input logic [AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [WAIT_W-1:0] wait_cycles,
	flash_bank_if.disp bank [NUM_BANKS],
	output logic order_push,
	output logic [BANK_W-1:0] order_bank,
	output logic order_err,
	input logic order_full
);

	logic ar_cfg;
	logic [BANK_W-1:0] ar_bank;
	logic [WORD_ADDR_W-1:0] ar_word;
	logic [NUM_BANKS-1:0] bank_ready;

	logic aw_held;
	logic w_held;
	logic [AXI_ADDR_W-1:0] aw_addr_q;
	logic [AXI_DATA_W-1:0] w_data_q;
	logic [AXI_DATA_W/8-1:0] w_strb_q;
	logic aw_fire;
	logic w_fire;
	logic wr_go;
	logic [AXI_ADDR_W-1:0] wr_addr;
	logic [AXI_DATA_W-1:0] wr_data;
	logic [AXI_DATA_W/8-1:0] wr_strb;
	logic wr_reg;

	// Bits 0 and 30:25 of the read address are ignored
	assign ar_cfg = araddr[CFG_BIT];
	assign ar_bank = araddr[BANK_LSB +: BANK_W];
	assign ar_word = araddr[WORD_ADDR_W:1];

	assign arready = !order_full && (ar_cfg || bank_ready[ar_bank]);

	assign order_push = arvalid && arready;
	assign order_bank = ar_bank;
	assign order_err = ar_cfg; // Register reads always answer SLVERR

	generate
		for (genvar i = 0; i < NUM_BANKS; i++) begin : g_disp
			assign bank_ready[i] = bank[i].req_ready;
			assign bank[i].req_valid = arvalid && !ar_cfg && !order_full &&
				(ar_bank == BANK_W'(i));
			assign bank[i].req_addr = ar_word;
		end
	endgenerate

	// Write address and data may arrive in either order
	assign awready = !bvalid && !aw_held;
	assign wready = !bvalid && !w_held;
	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;
	assign wr_go = (aw_fire || aw_held) && (w_fire || w_held);

	assign wr_addr = aw_held ? aw_addr_q : awaddr;
	assign wr_data = w_held ? w_data_q : wdata;
	assign wr_strb = w_held ? w_strb_q : wstrb;
	assign wr_reg = wr_addr[CFG_BIT] && (wr_addr[CFG_BIT-1:2] == '0);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
			bresp <= RESP_OKAY;
			wait_cycles <= WAIT_RESET;
		end else begin
			if (wr_go) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				bvalid <= 1'b1;
				bresp <= wr_addr[CFG_BIT] ? RESP_OKAY : RESP_SLVERR;
				if (wr_reg) begin
					for (int b = 0; b < WAIT_W; b++) begin
						if (wr_strb[b/8])
							wait_cycles[b] <= wr_data[b];
					end
				end
			end else begin
				if (aw_fire)
					aw_held <= 1'b1;
				if (w_fire)
					w_held <= 1'b1;
				if (bvalid && bready)
					bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_fire)
			aw_addr_q <= awaddr;
		if (w_fire) begin
			w_data_q <= wdata;
			w_strb_q <= wstrb;
		end
	end

endmodule

//--- src/flash_read_engine.sv
`timescale 1ns/1ns

module flash_read_engine import flash_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [WAIT_W-1:0] wait_cycles,
	flash_bank_if.engine bus,
	output logic [FLASH_ADDR_W-1:0] flash_addr,
	input logic [DATA_W-1:0] flash_dq_i,
	output logic [DATA_W-1:0] flash_dq_o,
	output logic flash_dq_oe,
	output logic flash_oe_n,
	output logic flash_we_n
);

	logic [PH_RSP:0] state; // One-hot
	logic [WAIT_W-1:0] wait_lat;
	logic [WAIT_W-1:0] cnt;
	logic req_ready;
	logic rsp_valid;
	logic [DATA_W-1:0] rsp_data;
	logic accept;
	logic phase_end;

	assign bus.req_ready = req_ready;
	assign bus.rsp_valid = rsp_valid;
	assign bus.rsp_data = rsp_data;

	assign accept = state[PH_IDLE] && bus.req_valid && req_ready;
	assign phase_end = (cnt == wait_lat);

	// Read-array is the only command ever written
	assign flash_dq_o = CMD_READ_ARRAY;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= {{PH_RSP{1'b0}}, 1'b1};
			cnt <= '0;
			req_ready <= 1'b0;
			rsp_valid <= 1'b0;
			flash_dq_oe <= 1'b0;
			flash_oe_n <= 1'b1;
			flash_we_n <= 1'b1;
		end else begin
			if (state[PH_IDLE] || state[PH_RSP] || phase_end)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;

			case (1'b1)
				state[PH_IDLE]: begin
					if (accept) begin
						req_ready <= 1'b0;
						flash_we_n <= 1'b0; // Command setup
						flash_dq_oe <= 1'b1;
						state <= state << 1;
					end else begin
						req_ready <= 1'b1;
					end
				end
				state[PH_CMD]: begin
					if (phase_end) begin
						flash_we_n <= 1'b1; // Chip latches the command here
						state <= state << 1;
					end
				end
				state[PH_WE]: begin
					if (phase_end) begin
						flash_dq_oe <= 1'b0;
						flash_oe_n <= 1'b0;
						state <= state << 1;
					end
				end
				state[PH_OE], state[PH_CAP]: begin
					if (phase_end)
						state <= state << 1;
				end
				state[PH_DONE]: begin
					if (phase_end) begin
						flash_oe_n <= 1'b1;
						rsp_valid <= 1'b1;
						state <= state << 1;
					end
				end
				state[PH_RSP]: begin
					// Hold the word until the collector takes it
					if (bus.rsp_ready) begin
						rsp_valid <= 1'b0;
						req_ready <= 1'b1;
						state <= {{PH_RSP{1'b0}}, 1'b1};
					end
				end
				default: state <= {{PH_RSP{1'b0}}, 1'b1};
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			flash_addr <= {bus.req_addr, 1'b0};
			wait_lat <= wait_cycles; // Sampled once per request
		end
		if (state[PH_CAP] && phase_end)
			rsp_data <= flash_dq_i;
	end

endmodule

//--- src/flash_rsp_collector.sv
`timescale 1ns/1ns

module flash_rsp_collector import flash_pkg::*; (
	input logic clk,
	input logic rst,
	input logic order_push,
	input logic [BANK_W-1:0] order_bank,
	input logic order_err,
	output logic order_full,
	flash_bank_if.coll bank [NUM_BANKS],
	output logic [AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	logic [BANK_W:0] order_mem [ORDER_DEPTH]; // {err, bank}
	logic [ORDER_PTR_W-1:0] wr_ptr;
	logic [ORDER_PTR_W-1:0] rd_ptr;
	logic [ORDER_PTR_W:0] count;
	logic head_err;
	logic [BANK_W-1:0] head_bank;
	logic slot_free;
	logic take_bank;
	logic take_err;
	logic pop;
	logic [NUM_BANKS-1:0] bank_valid;
	logic [DATA_W-1:0] bank_data [NUM_BANKS];

	assign {head_err, head_bank} = order_mem[rd_ptr];
	assign slot_free = !rvalid || rready;
	assign take_bank = (count != '0) && !head_err && slot_free;
	assign take_err = (count != '0) && head_err && slot_free;
	assign pop = take_err || (take_bank && bank_valid[head_bank]);
	assign order_full = (count == (ORDER_PTR_W + 1)'(ORDER_DEPTH));

	// Only the head bank sees ready, so replies stay in request order
	generate
		for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
			assign bank_valid[i] = bank[i].rsp_valid;
			assign bank_data[i] = bank[i].rsp_data;
			assign bank[i].rsp_ready = take_bank && (head_bank == BANK_W'(i));
		end
	endgenerate

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			rvalid <= 1'b0;
		end else begin
			if (order_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (order_push && !pop)
				count <= count + 1'b1;
			else if (!order_push && pop)
				count <= count - 1'b1;

			if (pop)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (order_push)
			order_mem[wr_ptr] <= {order_err, order_bank};
		if (pop) begin
			rdata <= take_err ? '0 : AXI_DATA_W'(bank_data[head_bank]);
			rresp <= take_err ? RESP_SLVERR : RESP_OKAY;
		end
	end

endmodule

//--- src/flash_array_top.sv
`timescale 1ns/1ns

module flash_array_top import flash_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [AXI_DATA_W-1:0] wdata,
	input logic [AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [AXI_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [NUM_BANKS-1:0][FLASH_ADDR_W-1:0] flash_addr,
	input logic [NUM_BANKS-1:0][DATA_W-1:0] flash_dq_i,
	output logic [NUM_BANKS-1:0][DATA_W-1:0] flash_dq_o,
	output logic [NUM_BANKS-1:0] flash_dq_oe,
	output logic [NUM_BANKS-1:0] flash_oe_n,
	output logic [NUM_BANKS-1:0] flash_we_n
);

	logic [WAIT_W-1:0] wait_cycles;
	logic order_push;
	logic [BANK_W-1:0] order_bank;
	logic order_err;
	logic order_full;

	flash_bank_if bank_if [NUM_BANKS] ();

	flash_axi_front u_front (
		.clk(clk),
		.rst(rst),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.wait_cycles(wait_cycles),
		.bank(bank_if),
		.order_push(order_push),
		.order_bank(order_bank),
		.order_err(order_err),
		.order_full(order_full)
	);

	generate
		for (genvar i = 0; i < NUM_BANKS; i++) begin : g_engine
			flash_read_engine u_engine (
				.clk(clk),
				.rst(rst),
				.wait_cycles(wait_cycles),
				.bus(bank_if[i]),
				.flash_addr(flash_addr[i]),
				.flash_dq_i(flash_dq_i[i]),
				.flash_dq_o(flash_dq_o[i]),
				.flash_dq_oe(flash_dq_oe[i]),
				.flash_oe_n(flash_oe_n[i]),
				.flash_we_n(flash_we_n[i])
			);
		end
	endgenerate

	flash_rsp_collector u_collector (
		.clk(clk),
		.rst(rst),
		.order_push(order_push),
		.order_bank(order_bank),
		.order_err(order_err),
		.order_full(order_full),
		.bank(bank_if),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

endmodule

//--- tests/flash_chip_model.sv
`timescale 1ns/1ns

module flash_chip_model import flash_pkg::*; #(
	parameter int BANK = 0
) (
	input logic [FLASH_ADDR_W-1:0] addr,
	input logic [DATA_W-1:0] dq_o,
	input logic dq_oe,
	input logic oe_n,
	input logic we_n,
	output logic [DATA_W-1:0] dq_i
);

	logic read_mode;
	logic [21:0] word;
	logic [15:0] pattern;

	initial read_mode = 1'b0;

	// Command is latched on the rising edge of write-enable
	always @(posedge we_n) begin
		if (dq_oe === 1'b1)
			read_mode <= (dq_o === CMD_READ_ARRAY);
	end

	assign word = addr[22:1];
	assign pattern = (word[15:0] * 16'h9e37 + 16'(BANK) * 16'h1111) ^ {10'd0, word[21:16]};
	assign dq_i = (read_mode && !oe_n) ? pattern : 16'hdead;

endmodule

//--- tests/flash_checker.sv
`timescale 1ns/1ns

module flash_checker import flash_pkg::*; #(
	parameter int CYCLE_LIMIT = 20000
) (
	input logic clk,
	input logic rst,
	input logic [31:0] awaddr,
	input logic awvalid,
	input logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready,
	input logic [31:0] araddr,
	input logic arvalid,
	input logic arready,
	input logic [31:0] rdata,
	input logic [1:0] rresp,
	input logic rvalid,
	input logic rready,
	input logic report,
	output int error_count,
	output logic timed_out
);

	logic [31:0] exp_data [$];
	logic [1:0] exp_rresp [$];
	int exp_cycle [$];
	int exp_min [$];
	logic [1:0] exp_bresp [$];
	logic [8:0] wait_model;
	logic [31:0] aw_addr;
	logic [31:0] w_data;
	logic [3:0] w_strb;
	logic aw_seen;
	logic w_seen;
	logic head_seen;
	int cycle;
	int reads;
	int writes;
	int data_errs;
	int resp_errs;
	int other_errs;
	int end_errs;

	initial begin
		wait_model = 9'd3;
		{aw_seen, w_seen, head_seen, timed_out} = '0;
		{cycle, reads, writes, data_errs, resp_errs, other_errs, end_errs} = '0;
	end

	assign error_count = data_errs + resp_errs + other_errs + end_errs;

	function automatic logic [15:0] pattern_word(logic [1:0] bank, logic [21:0] word);
		return (word[15:0] * 16'h9e37 + {14'd0, bank} * 16'h1111) ^ {10'd0, word[21:16]};
	endfunction

	task automatic print_counts();
		$display("Checked %0d reads and %0d writes: %0d data, %0d response, %0d other errors",
			reads, writes, data_errs, resp_errs, other_errs + end_errs);
	endtask

	always @(posedge clk) begin
		cycle++;
		if (rst) begin
			// Latency is measured at the first cycle of each reply
			if (rvalid && !head_seen) begin
				head_seen = 1'b1;
				if (exp_data.size() == 0) begin
					$display("rvalid was raised while no read was outstanding");
					other_errs++;
				end else if (cycle - exp_cycle[0] < exp_min[0]) begin
					$display("Read reply came %0d cycles after acceptance, minimum is %0d",
						cycle - exp_cycle[0], exp_min[0]);
					other_errs++;
				end
			end
			if (rvalid && rready && exp_data.size() != 0) begin
				head_seen = 1'b0;
				if (rdata !== exp_data[0]) begin
					$display("Error: rdata = %h, expected %h", rdata, exp_data[0]);
					data_errs++;
				end
				if (rresp !== exp_rresp[0]) begin
					$display("Error: rresp = %h, expected %h", rresp, exp_rresp[0]);
					resp_errs++;
				end
				void'(exp_data.pop_front());
				void'(exp_rresp.pop_front());
				void'(exp_cycle.pop_front());
				void'(exp_min.pop_front());
				reads++;
			end else if (rvalid && rready) begin
				head_seen = 1'b0;
			end
			if (arvalid && arready) begin
				exp_cycle.push_back(cycle);
				if (araddr[31]) begin
					exp_data.push_back('0);
					exp_rresp.push_back(2'b10);
					exp_min.push_back(0);
				end else begin
					exp_data.push_back({16'd0, pattern_word(araddr[24:23], araddr[22:1])});
					exp_rresp.push_back(2'b00);
					exp_min.push_back(5 * (wait_model + 1));
				end
			end
			if (awvalid && awready) begin
				aw_addr = awaddr;
				aw_seen = 1'b1;
			end
			if (wvalid && wready) begin
				w_data = wdata;
				w_strb = wstrb;
				w_seen = 1'b1;
			end
			if (aw_seen && w_seen) begin
				exp_bresp.push_back(aw_addr[31] ? 2'b00 : 2'b10);
				if (aw_addr[31] && aw_addr[30:2] == '0) begin
					if (w_strb[0])
						wait_model[7:0] = w_data[7:0];
					if (w_strb[1])
						wait_model[8] = w_data[8];
				end
				{aw_seen, w_seen} = 2'b00;
			end
			if (bvalid && bready) begin
				if (exp_bresp.size() == 0) begin
					$display("bvalid was raised while no write was outstanding");
					other_errs++;
				end else begin
					if (bresp !== exp_bresp[0]) begin
						$display("Error: bresp = %h, expected %h", bresp, exp_bresp[0]);
						resp_errs++;
					end
					void'(exp_bresp.pop_front());
					writes++;
				end
			end
		end
		if (cycle == CYCLE_LIMIT && !timed_out) begin
			$display("Timeout: run reached its limit of %0d cycles with %0d reads pending",
				CYCLE_LIMIT, exp_data.size());
			print_counts();
			timed_out = 1'b1;
		end
	end

	always @(posedge report) begin
		if (exp_data.size() != 0 || exp_bresp.size() != 0) begin
			$display("%0d reads and %0d writes never got a reply",
				exp_data.size(), exp_bresp.size());
			end_errs++;
		end
		print_counts();
	end

endmodule

//--- tests/tb_flash_array.sv
`timescale 1ns/1ns

module tb_flash_array import flash_pkg::*; ;

	localparam int NUM_TRANS = 400;
	localparam int MAX_WAIT = 6;
	localparam int CYCLE_LIMIT = NUM_TRANS * (5 * (MAX_WAIT + 1) + 10) + 2000;

	logic clk;
	logic rst;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [NUM_BANKS-1:0][FLASH_ADDR_W-1:0] flash_addr;
	logic [NUM_BANKS-1:0][DATA_W-1:0] flash_dq_i;
	logic [NUM_BANKS-1:0][DATA_W-1:0] flash_dq_o;
	logic [NUM_BANKS-1:0] flash_dq_oe;
	logic [NUM_BANKS-1:0] flash_oe_n;
	logic [NUM_BANKS-1:0] flash_we_n;
	logic report;
	int error_count;
	logic timed_out;
	int seed;
	int ready_pct;
	int reads_sent;
	int reads_done;
	int bank;
	logic [31:0] addr;

	flash_array_top u_dut (.*);

	flash_checker #(.CYCLE_LIMIT(CYCLE_LIMIT)) u_checker (.*);

	generate
		for (genvar i = 0; i < NUM_BANKS; i++) begin : g_chip
			flash_chip_model #(.BANK(i)) u_chip (
				.addr(flash_addr[i]),
				.dq_o(flash_dq_o[i]),
				.dq_oe(flash_dq_oe[i]),
				.oe_n(flash_oe_n[i]),
				.we_n(flash_we_n[i]),
				.dq_i(flash_dq_i[i])
			);
		end
	endgenerate

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] make_flash_addr(int b, logic [21:0] word);
		return {7'd0, 2'(b), word, 1'b0};
	endfunction

	// Tasks start at a rising edge and return at one
	task automatic send_read(input logic [31:0] a);
		#2;
		araddr = a;
		arvalid = 1'b1;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		reads_sent++;
	endtask

	task automatic end_reads();
		#2 arvalid = 1'b0;
		while (reads_done != reads_sent)
			@(posedge clk);
	endtask

	task automatic send_write(input logic [31:0] a, input logic [31:0] d);
		#2;
		{awaddr, wdata, wstrb} = {a, d, 4'hf};
		{awvalid, wvalid} = 2'b11;
		@(posedge clk);
		while (!(awready && wready))
			@(posedge clk);
		#2 {awvalid, wvalid} = 2'b00;
		@(posedge clk);
		while (!bvalid)
			@(posedge clk);
	endtask

	initial begin
		rready = 1'b0;
		forever begin
			@(posedge clk);
			#2 rready = rand_below(100) < ready_pct;
		end
	end

	always @(posedge clk) begin
		if (rst && rvalid && rready)
			reads_done <= reads_done + 1;
	end

	initial begin
		wait (timed_out === 1'b1);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 32'h6b3b_e3d2;
		{rst, awvalid, wvalid, arvalid, report} = '0;
		{awaddr, wdata, araddr, wstrb} = '0;
		bready = 1'b1;
		ready_pct = 50;
		{reads_sent, reads_done} = '0;
		repeat (8) @(posedge clk);
		#2 rst = 1'b1;
		repeat (2) @(posedge clk);

		repeat (100) begin
			send_read(make_flash_addr(rand_below(4), 22'($random(seed))));
			end_reads();
		end

		ready_pct = 25; // Slow reader lets the replies back up
		bank = 0;
		repeat (120) begin
			bank = (bank + 1 + rand_below(3)) % 4;
			send_read(make_flash_addr(bank, 22'($random(seed))));
		end
		end_reads();
		ready_pct = 70;

		send_write(32'h8000_0000, MAX_WAIT);
		repeat (30) begin
			send_read(make_flash_addr(rand_below(4), 22'($random(seed))));
			end_reads();
		end
		send_write(32'h8000_0000, 0);
		repeat (30)
			send_read(make_flash_addr(rand_below(4), 22'($random(seed))));
		end_reads();
		send_write(32'h8000_0000, 3);

		send_write(make_flash_addr(rand_below(4), 22'($random(seed))), 32'h1234);
		repeat (40) begin
			if (rand_below(3) == 0)
				send_read({1'b1, 31'($random(seed))});
			else
				send_read(make_flash_addr(rand_below(4), 22'($random(seed))));
		end
		end_reads();

		// Same word with and without the ignored bits
		repeat (20) begin
			addr = make_flash_addr(rand_below(4), 22'($random(seed)));
			send_read(addr | {1'b0, 6'($random(seed)), 25'd1});
			send_read(addr);
		end
		end_reads();

		repeat (4) @(posedge clk);
		report = 1'b1;
		#1;
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- compile.f
src/flash_pkg.sv
src/flash_bank_if.sv
src/flash_axi_front.sv
src/flash_read_engine.sv
src/flash_rsp_collector.sv
src/flash_array_top.sv
tests/flash_chip_model.sv
tests/flash_checker.sv
tests/tb_flash_array.sv

//--- run.sh
#!/bin/sh
# Build and run the flash array testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_flash_array -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_flash_array > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
